/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Uncached peripheral windows
    localparam logic [63:0] UART_BASE  = 64'h0000_0000_1000_0000;
    localparam logic [63:0] UART_LAST  = 64'h0000_0000_1000_0FFF;
    localparam logic [63:0] SPI_BASE   = 64'h0000_0000_1000_1000;
    localparam logic [63:0] SPI_LAST   = 64'h0000_0000_1000_1FFF;
    localparam logic [63:0] CLINT_BASE = 64'h0000_0000_0200_0000;
    localparam logic [63:0] CLINT_LAST = 64'h0000_0000_0200_FFFF;

    // Doublewords in the data store
    localparam int STORE_DEPTH = 256;

    // 32-bit registers per peripheral bank
    localparam int MMIO_WORDS = 16;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } data_half_t;

    // Whole doubleword, or split into the two bus-width halves
    typedef union packed {
        logic [63:0] dw;
        data_half_t  half;
    } data_word_u;

    typedef struct packed {
        logic [63:0] addr;
        data_word_u  wdata;
        logic [7:0]  mask;
        logic        we;
        logic        re;
    } mem_req_t;

    typedef struct packed {
        data_word_u rdata;
    } mem_rsp_t;

    // One 32-bit peripheral bus beat
    typedef struct packed {
        logic [63:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        logic        we;
    } bus_req_t;

endpackage

`default_nettype wire

/* dv/mem_subsys_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_asserts (
    input wire                     clk,
    input wire                     rst_n,
    input wire mem_pkg::mem_req_t  core_req,
    input wire                     core_valid,
    input wire                     core_ack,
    input wire                     store_valid,
    input wire mem_pkg::bus_req_t  bus_req,
    input wire                     bus_valid,
    input wire                     bus_ack
);

    int fail_count = 0;

    // Four-phase ordering on the core link
    core_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(core_ack) |-> $past(core_valid))
        else begin
            $error("core_ack rose while core_valid was low");
            fail_count++;
        end

    core_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(core_ack) |-> !$past(core_valid))
        else begin
            $error("core_ack fell while core_valid was still high");
            fail_count++;
        end

    // Same ordering on the peripheral bus
    bus_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_ack) |-> $past(bus_valid))
        else begin
            $error("bus_ack rose while bus_valid was low");
            fail_count++;
        end

    bus_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(bus_ack) |-> !$past(bus_valid))
        else begin
            $error("bus_ack fell while bus_valid was still high");
            fail_count++;
        end

    core_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (core_valid || core_ack) && $past(core_valid || core_ack) |-> $stable(core_req))
        else begin
            $error("core request changed during a transfer");
            fail_count++;
        end

    bus_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_valid || bus_ack) && $past(bus_valid || bus_ack) |-> $stable(bus_req))
        else begin
            $error("bus request changed during a beat");
            fail_count++;
        end

    one_target: assert property (@(posedge clk) disable iff (!rst_n)
        !(store_valid && bus_valid))
        else begin
            $error("store and peripheral bus requested together");
            fail_count++;
        end

    // Cached access completes at the core in a single cycle
    store_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(store_valid) |=> $rose(core_ack))
        else begin
            $error("cached access did not ack one cycle after valid");
            fail_count++;
        end

endmodule

bind mem_subsys_top mem_subsys_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .core_req    (core_req),
    .core_valid  (core_valid),
    .core_ack    (core_ack),
    .store_valid (store_valid),
    .bus_req     (bus_req),
    .bus_valid   (bus_valid),
    .bus_ack     (bus_ack)
);

`default_nettype wire

/* dv/tb_mem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int CLK_PERIOD        = 100;
    localparam int MAX_ACCESSES      = 400;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam logic [63:0] CACHED_BASE = 64'h0000_0000_8000_0000;

    logic       clk = 1'b0;
    logic       rst_n;
    mem_req_t   core_req;
    logic       core_valid;
    logic       core_ack;
    mem_rsp_t   core_rsp;
    logic       soft_irq;

    int errors;
    int checks;
    int seed;

    // Expected contents keyed by store index or by bank * MMIO_WORDS + word
    logic [63:0] store_model [int];
    logic [31:0] mmio_model [int];

    mem_subsys_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_valid (core_valid),
        .core_ack   (core_ack),
        .core_rsp   (core_rsp),
        .soft_irq   (soft_irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(MAX_ACCESSES * CYCLES_PER_ACCESS * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d accesses", MAX_ACCESSES);
        $display("FAIL: see errors above");
        $finish;
    end

    // -1 for cached space, else bank 0, 1, 2 for UART, SPI, CLINT
    function automatic int window_of(input logic [63:0] addr);
        if (addr >= UART_BASE && addr <= UART_LAST) return 0;
        if (addr >= SPI_BASE && addr <= SPI_LAST) return 1;
        if (addr >= CLINT_BASE && addr <= CLINT_LAST) return 2;
        return -1;
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_v,
                                                input logic [63:0] new_v,
                                                input logic [7:0] mask);
        logic [63:0] res;
        res = old_v;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] mmio_word(input int key);
        if (mmio_model.exists(key)) return mmio_model[key];
        return 32'h0;
    endfunction

    // High half sits in the word with bit 2 set
    function automatic int hi_key(input logic [63:0] addr);
        return window_of(addr) * MMIO_WORDS + 2 * int'(addr[5:3]) + 1;
    endfunction

    function automatic logic [63:0] model_read(input logic [63:0] addr);
        int key;
        if (window_of(addr) < 0) begin
            key = int'(addr[10:3]);
            if (store_model.exists(key)) return store_model[key];
            return {64{1'bx}};
        end
        key = hi_key(addr);
        return {mmio_word(key), mmio_word(key - 1)};
    endfunction

    function automatic void model_write(input logic [63:0] addr, input logic [63:0] data,
                                        input logic [7:0] mask);
        int          key;
        logic [63:0] new_v;
        new_v = merge_bytes(model_read(addr), data, mask);
        if (window_of(addr) < 0) begin
            store_model[int'(addr[10:3])] = new_v;
        end else begin
            key = hi_key(addr);
            mmio_model[key]     = new_v[63:32];
            mmio_model[key - 1] = new_v[31:0];
        end
    endfunction

    function automatic void check_value(input logic [63:0] got, input logic [63:0] exp,
                                        input string what);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
            errors++;
        end
    endfunction

    task automatic do_access(input logic [63:0] addr, input logic [63:0] wdata,
                             input logic [7:0] mask, input logic we,
                             output logic [63:0] rdata);
        @(posedge clk);
        core_req.addr     <= addr;
        core_req.wdata.dw <= wdata;
        core_req.mask     <= mask;
        core_req.we       <= we;
        core_req.re       <= ~we;
        core_valid        <= 1'b1;
        @(negedge clk);
        while (!core_ack) @(negedge clk);
        rdata = core_rsp.rdata.dw;
        @(posedge clk);
        core_valid <= 1'b0;
        @(negedge clk);
        while (core_ack) @(negedge clk);
    endtask

    task automatic write_dw(input logic [63:0] addr, input logic [63:0] data,
                            input logic [7:0] mask);
        logic [63:0] ignored;
        do_access(addr, data, mask, 1'b1, ignored);
        model_write(addr, data, mask);
    endtask

    task automatic read_check(input logic [63:0] addr, input string what);
        logic [63:0] rd;
        do_access(addr, 64'h0, 8'h00, 1'b0, rd);
        check_value(rd, model_read(addr), what);
    endtask

    task automatic test_reset();
        logic [63:0] rd;
        @(negedge clk);
        check_value({63'h0, core_ack}, 64'h0, "core_ack low after reset");
        check_value({63'h0, soft_irq}, 64'h0, "soft_irq low after reset");
        for (int off = 0; off < 64; off += 8) begin
            do_access(UART_BASE + 64'(off), 64'h0, 8'h00, 1'b0, rd);
            check_value(rd, 64'h0, "UART register after reset");
            do_access(SPI_BASE + 64'(off), 64'h0, 8'h00, 1'b0, rd);
            check_value(rd, 64'h0, "SPI register after reset");
            do_access(CLINT_BASE + 64'(off), 64'h0, 8'h00, 1'b0, rd);
            check_value(rd, 64'h0, "CLINT register after reset");
        end
    endtask

    task automatic test_cached();
        logic [63:0] a;
        a = CACHED_BASE + 64'h40;
        write_dw(a, 64'h0123_4567_89ab_cdef, 8'hff);
        read_check(a, "cached full write");
        write_dw(a, 64'hffee_ddcc_bbaa_9988, 8'h5a);
        read_check(a, "cached partial write");
        // Bit 11 is above the index, so this lands on the same entry
        write_dw(a + 64'h800, 64'h1111_2222_3333_4444, 8'h0f);
        read_check(a, "aliased write seen at first address");
        read_check(a + 64'h800, "aliased address read");
        write_dw(CACHED_BASE + 64'h7f8, 64'hdead_beef_0bad_f00d, 8'hff);
        read_check(CACHED_BASE + 64'h7f8, "last store entry");
    endtask

    task automatic test_uncached();
        logic [63:0] a;
        a = UART_BASE + 64'h10;
        write_dw(a, 64'hcafe_f00d_1234_5678, 8'hff);
        read_check(a, "UART full write");
        check_value({32'h0, DUT.u_mmio.regs[0][5]}, 64'hcafe_f00d, "high half in word 5");
        check_value({32'h0, DUT.u_mmio.regs[0][4]}, 64'h1234_5678, "low half in word 4");
        write_dw(a, 64'h0, 8'h81);
        read_check(a, "UART outer bytes cleared");
        write_dw(a, 64'h5566_7788_99aa_bbcc, 8'h3c);
        read_check(a, "UART middle bytes written");
    endtask

    task automatic test_regions();
        write_dw(UART_BASE + 64'h20, 64'h1111_1111_aaaa_aaaa, 8'hff);
        write_dw(SPI_BASE + 64'h20, 64'h2222_2222_bbbb_bbbb, 8'hff);
        write_dw(CLINT_BASE + 64'h20, 64'h3333_3333_cccc_cccc, 8'hff);
        write_dw(CACHED_BASE + 64'h20, 64'h4444_4444_dddd_dddd, 8'hff);
        read_check(UART_BASE + 64'h20, "UART region value");
        read_check(SPI_BASE + 64'h20, "SPI region value");
        read_check(CLINT_BASE + 64'h20, "CLINT region value");
        read_check(CACHED_BASE + 64'h20, "cached region value");
    endtask

    task automatic test_soft_irq();
        write_dw(CLINT_BASE, 64'h1, 8'h01);
        check_value({63'h0, soft_irq}, 64'h1, "soft_irq set by msip write");
        write_dw(CLINT_BASE, 64'h0, 8'hfe);
        check_value({63'h0, soft_irq}, 64'h1, "soft_irq kept with byte 0 masked");
        write_dw(CLINT_BASE, 64'h0, 8'h01);
        check_value({63'h0, soft_irq}, 64'h0, "soft_irq cleared");
        write_dw(CLINT_BASE, 64'h1, 8'hfe);
        check_value({63'h0, soft_irq}, 64'h0, "soft_irq stays clear with byte 0 masked");
        read_check(CLINT_BASE, "CLINT word 0 pair");
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        logic [63:0] addr;
        logic [63:0] data;
        // Store entries used below start from known values
        for (int i = 0; i < 16; i++) begin
            write_dw(CACHED_BASE + 64'(i) * 64'd8, {32'h5a5a_0000, 32'(i)}, 8'hff);
        end
        for (int n = 0; n < 300; n++) begin
            rnd = $random(seed);
            data[63:32] = $random(seed);
            data[31:0]  = $random(seed);
            case (rnd[7:6])
                2'd0: addr = CACHED_BASE + {51'h0, rnd[5:4], 4'h0, rnd[3:0], 3'b000};
                2'd1: addr = UART_BASE + {56'h0, rnd[4:0], 3'b000};
                2'd2: addr = SPI_BASE + {56'h0, rnd[4:0], 3'b000};
                default: addr = CLINT_BASE + {56'h0, rnd[4:0], 3'b000};
            endcase
            if (rnd[8]) begin
                write_dw(addr, data, rnd[23:16]);
            end else begin
                read_check(addr, "random read");
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        core_req   = '0;
        core_valid = 1'b0;
        errors     = 0;
        checks     = 0;
        seed       = 32'hf93d_50c8;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_cached();
        test_uncached();
        test_regions();
        test_soft_irq();
        test_random();

        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_asserts.fail_count);
        if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/mem_pkg.sv
uncache/uncache_router.sv
uncache/uncache_splitter.sv
verilog/data_store.sv
verilog/mmio_regs.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_asserts.sv
dv/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsys \
    -f project.f \
    -o tb_mem_subsys

./obj_dir/tb_mem_subsys | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* uncache/uncache_router.sv */
`timescale 1ns/100ps
`default_nettype none

module uncache_router (
    input  wire  mem_pkg::mem_req_t  core_req,
    input  wire                      core_valid,
    output logic                     core_ack,
    output mem_pkg::mem_rsp_t        core_rsp,

    output mem_pkg::mem_req_t        store_req,
    output logic                     store_valid,
    input  wire                      store_ack,
    input  wire  mem_pkg::mem_rsp_t  store_rsp,

    output mem_pkg::mem_req_t        split_req,
    output logic                     split_valid,
    input  wire                      split_ack,
    input  wire  mem_pkg::mem_rsp_t  split_rsp
);
    import mem_pkg::*;

    logic in_uart;
    logic in_spi;
    logic in_clint;
    logic uncached;

    assign in_uart  = (core_req.addr >= UART_BASE) && (core_req.addr <= UART_LAST);
    assign in_spi   = (core_req.addr >= SPI_BASE) && (core_req.addr <= SPI_LAST);
    assign in_clint = (core_req.addr >= CLINT_BASE) && (core_req.addr <= CLINT_LAST);

    // Address is held by the core until ack falls, so the steering is stable
    assign uncached = in_uart | in_spi | in_clint;

    // Unused target sees an all-zero request
    assign store_req = uncached ? '0 : core_req;
    assign split_req = uncached ? core_req : '0;

    assign store_valid = core_valid & ~uncached;
    assign split_valid = core_valid & uncached;

    assign core_ack = uncached ? split_ack : store_ack;
    assign core_rsp = uncached ? split_rsp : store_rsp;

endmodule

`default_nettype wire

/* uncache/uncache_splitter.sv */
`timescale 1ns/100ps
`default_nettype none

module uncache_splitter (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire  mem_pkg::mem_req_t  split_req,
    input  wire                      split_valid,
    output logic                     split_ack,
    output mem_pkg::mem_rsp_t        split_rsp,

    output mem_pkg::bus_req_t        bus_req,
    output logic                     bus_valid,
    input  wire                      bus_ack,
    input  wire  [31:0]              bus_rdata
);
    import mem_pkg::*;

    enum logic [2:0] {
        S_IDLE,
        S_HI_REQ,
        S_HI_REL,
        S_LO_REQ,
        S_LO_REL,
        S_DONE
    } state, state_nxt;

    data_word_u rdata_q;
    logic       lo_beat;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (split_valid) begin
                    state_nxt = S_HI_REQ;
                end
            end
            S_HI_REQ: begin
                if (bus_ack) begin
                    state_nxt = S_HI_REL;
                end
            end
            // Wait for the slave to drop ack before the next beat
            S_HI_REL: begin
                if (!bus_ack) begin
                    state_nxt = S_LO_REQ;
                end
            end
            S_LO_REQ: begin
                if (bus_ack) begin
                    state_nxt = S_LO_REL;
                end
            end
            S_LO_REL: begin
                if (!bus_ack) begin
                    state_nxt = S_DONE;
                end
            end
            S_DONE: begin
                if (!split_valid) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Read halves land as each beat is acked
    always_ff @(posedge clk) begin
        if (state == S_HI_REQ && bus_ack) begin
            rdata_q.half.hi <= bus_rdata;
        end
        if (state == S_LO_REQ && bus_ack) begin
            rdata_q.half.lo <= bus_rdata;
        end
    end

    // Beat fields stay put through each release phase
    assign lo_beat = (state == S_LO_REQ) || (state == S_LO_REL) || (state == S_DONE);

    assign bus_req.addr  = {split_req.addr[63:3], ~lo_beat, 2'b00};
    assign bus_req.wdata = lo_beat ? split_req.wdata.half.lo : split_req.wdata.half.hi;
    assign bus_req.mask  = lo_beat ? split_req.mask[3:0] : split_req.mask[7:4];
    assign bus_req.we    = split_req.we;

    assign bus_valid = (state == S_HI_REQ) || (state == S_LO_REQ);

    assign split_ack       = (state == S_DONE);
    assign split_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module data_store (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire  mem_pkg::mem_req_t  store_req,
    input  wire                      store_valid,
    output logic                     store_ack,
    output mem_pkg::mem_rsp_t        store_rsp
);
    import mem_pkg::*;

    data_word_u                       mem [STORE_DEPTH];
    data_word_u                       rdata_q;
    logic [$clog2(STORE_DEPTH)-1:0]   idx;

    // Upper address bits alias onto the same entry
    assign idx = store_req.addr[$clog2(STORE_DEPTH)+2:3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_ack <= 1'b0;
        end else begin
            store_ack <= store_valid;
        end
    end

    // Act once, on the edge that raises ack
    always_ff @(posedge clk) begin
        if (store_valid && !store_ack) begin
            rdata_q <= mem[idx];
            if (store_req.we) begin
                for (int b = 0; b < 8; b++) begin
                    if (store_req.mask[b]) begin
                        mem[idx].dw[8*b +: 8] <= store_req.wdata.dw[8*b +: 8];
                    end
                end
            end
        end
    end

    assign store_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/mem_subsys_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire  mem_pkg::mem_req_t  core_req,
    input  wire                      core_valid,
    output logic                     core_ack,
    output mem_pkg::mem_rsp_t        core_rsp,

    output logic                     soft_irq
);
    import mem_pkg::*;

    mem_req_t    store_req;
    logic        store_valid;
    logic        store_ack;
    mem_rsp_t    store_rsp;

    mem_req_t    split_req;
    logic        split_valid;
    logic        split_ack;
    mem_rsp_t    split_rsp;

    bus_req_t    bus_req;
    logic        bus_valid;
    logic        bus_ack;
    logic [31:0] bus_rdata;

    uncache_router u_router (
        .core_req    (core_req),
        .core_valid  (core_valid),
        .core_ack    (core_ack),
        .core_rsp    (core_rsp),
        .store_req   (store_req),
        .store_valid (store_valid),
        .store_ack   (store_ack),
        .store_rsp   (store_rsp),
        .split_req   (split_req),
        .split_valid (split_valid),
        .split_ack   (split_ack),
        .split_rsp   (split_rsp)
    );

    uncache_splitter u_splitter (
        .clk         (clk),
        .rst_n       (rst_n),
        .split_req   (split_req),
        .split_valid (split_valid),
        .split_ack   (split_ack),
        .split_rsp   (split_rsp),
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata)
    );

    data_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_req   (store_req),
        .store_valid (store_valid),
        .store_ack   (store_ack),
        .store_rsp   (store_rsp)
    );

    mmio_regs u_mmio (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .soft_irq    (soft_irq)
    );

endmodule

`default_nettype wire

/* verilog/mmio_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mmio_regs (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire  mem_pkg::bus_req_t  bus_req,
    input  wire                      bus_valid,
    output logic                     bus_ack,
    output logic [31:0]              bus_rdata,

    output logic                     soft_irq
);
    import mem_pkg::*;

    // Banks 0, 1, 2 are UART, SPI, CLINT
    logic [31:0]                     regs [3][MMIO_WORDS];
    logic [1:0]                      bank;
    logic                            hit;
    logic [$clog2(MMIO_WORDS)-1:0]   widx;

    always_comb begin
        hit  = 1'b1;
        bank = 2'd0;
        if ((bus_req.addr >= UART_BASE) && (bus_req.addr <= UART_LAST)) begin
            bank = 2'd0;
        end else if ((bus_req.addr >= SPI_BASE) && (bus_req.addr <= SPI_LAST)) begin
            bank = 2'd1;
        end else if ((bus_req.addr >= CLINT_BASE) && (bus_req.addr <= CLINT_LAST)) begin
            bank = 2'd2;
        end else begin
            hit = 1'b0;
        end
    end

    // Higher offsets alias within the bank
    assign widx = bus_req.addr[$clog2(MMIO_WORDS)+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_ack   <= 1'b0;
            bus_rdata <= '0;
            for (int k = 0; k < 3; k++) begin
                for (int w = 0; w < MMIO_WORDS; w++) begin
                    regs[k][w] <= '0;
                end
            end
        end else begin
            bus_ack <= bus_valid;
            if (bus_valid && !bus_ack) begin
                if (hit) begin
                    bus_rdata <= regs[bank][widx];
                    if (bus_req.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (bus_req.mask[b]) begin
                                regs[bank][widx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    bus_rdata <= '0;
                end
            end
        end
    end

    // msip lives in CLINT word 0
    assign soft_irq = regs[2][0][0];

endmodule

`default_nettype wire
